// ==== rv_isa_pkg.sv ====
// RV32I instruction encodings
package rv_isa_pkg;

    typedef logic [2:0] funct3_t;  // minor operation field
    typedef logic [4:0] reg_idx_t; // x0..x31

    // major opcodes kept by the core
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011, // reg-reg alu
        opc_op_imm = 7'b0010011, // reg-imm alu and shifts
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_other  = 7'b0000000  // anything else runs as a no-op
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b // lui
    } alu_op_t;

    // register write source
    typedef enum logic [1:0] {
        wb_alu,
        wb_load,
        wb_pc_plus4
    } wb_sel_t;

endpackage

// ==== cpu_types_pkg.sv ====
// core datapath and sequencing types
package cpu_types_pkg;

    typedef logic [31:0] word_t;     // data and address word
    typedef logic [3:0]  byte_mask_t; // one bit per byte lane

    // one pass through all seven states per instruction
    typedef enum logic [2:0] {
        st_fetch_req,  // instr_read high
        st_fetch_wait, // memory presents the word
        st_decode,     // instruction register loads
        st_execute,    // alu writeback, strobes, pc_next
        st_mem_wait,   // load data arrives
        st_load_wb,    // load writeback
        st_next        // pc advances
    } seq_state_t;

    localparam int CYCLES_PER_INSTR = 7;

endpackage

// ==== cpu_sequencer.sv ====
// seven-state instruction sequencer
`timescale 1ns/1ps
module cpu_sequencer #(
    parameter cpu_types_pkg::word_t RESET_PC = '0
) (
    input  logic                 clk,
    input  logic                 rst,
    input  cpu_types_pkg::word_t instr_out,
    input  logic                 is_load,
    input  logic                 is_store,
    input  logic                 is_branch,
    input  logic                 is_jal,
    input  logic                 is_jalr,
    input  logic                 branch_taken,
    input  logic                 rd_we,
    input  cpu_types_pkg::word_t imm,
    input  cpu_types_pkg::word_t alu_result,
    output logic                 instr_read,
    output logic                 data_read,
    output cpu_types_pkg::word_t instr_addr,
    output logic                 instr_load,
    output logic                 reg_we_alu,
    output logic                 reg_we_load,
    output logic                 mem_write_en
);
    import cpu_types_pkg::*;

    seq_state_t state;
    seq_state_t state_nx;
    word_t      pc_next;   // target registered in execute
    word_t      pc_target;

    always_comb
    begin
        case (state)
            st_fetch_req:  state_nx = st_fetch_wait;
            st_fetch_wait: state_nx = st_decode;
            st_decode:     state_nx = st_execute;
            st_execute:    state_nx = st_mem_wait;
            st_mem_wait:   state_nx = st_load_wb;
            st_load_wb:    state_nx = st_next;
            default:       state_nx = st_fetch_req;
        endcase
    end

    always_comb
    begin
        if ((is_branch && branch_taken) || is_jal)
            pc_target = instr_addr + imm;            // pc-relative
        else if (is_jalr)
            pc_target = {alu_result[31:1], 1'b0};    // rs1 + imm with bit 0 dropped
        else
            pc_target = instr_addr + 32'd4;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state      <= st_fetch_req;
            instr_addr <= RESET_PC;
            pc_next    <= RESET_PC;
        end
        else
        begin
            state <= state_nx;
            if (state == st_execute)
                pc_next <= pc_target;
            if (state == st_next)
                instr_addr <= pc_next; // holds from fetch_req to here
        end
    end

    // strobes are decoded straight from the state
    assign instr_read   = (state == st_fetch_req);
    assign instr_load   = (state == st_decode);
    assign data_read    = (state == st_execute) && is_load;
    assign mem_write_en = (state == st_execute) && is_store;
    assign reg_we_alu   = (state == st_execute) && rd_we && !is_load;
    assign reg_we_load  = (state == st_load_wb) && rd_we && is_load;

    // a load and a store never share the execute cycle
    a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
        !(data_read && mem_write_en));

    // the instruction memory has answered by the time decode latches
    a_fetch_known: assert property (@(posedge clk) disable iff (rst)
        instr_load |-> !$isunknown(instr_out));

endmodule

// ==== instr_decoder.sv ====
// instruction register and control decode
`timescale 1ns/1ps
module instr_decoder (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 instr_load,
    input  cpu_types_pkg::word_t instr_out,
    output rv_isa_pkg::reg_idx_t rs1,
    output rv_isa_pkg::reg_idx_t rs2,
    output rv_isa_pkg::reg_idx_t rd,
    output rv_isa_pkg::funct3_t  funct3,
    output cpu_types_pkg::word_t imm,
    output rv_isa_pkg::alu_op_t  alu_op,
    output logic                 use_imm,
    output logic                 use_pc,
    output rv_isa_pkg::wb_sel_t  wb_sel,
    output logic                 rd_we,
    output logic                 is_load,
    output logic                 is_store,
    output logic                 is_branch,
    output logic                 is_jal,
    output logic                 is_jalr
);
    import rv_isa_pkg::*;
    import cpu_types_pkg::*;

    word_t   ir;       // zero after reset decodes as a no-op
    opcode_t opcode;
    alu_op_t arith_op; // shared by op and op_imm
    word_t   imm_i;
    word_t   imm_s;
    word_t   imm_b;
    word_t   imm_u;
    word_t   imm_j;

    always_ff @(posedge clk)
    begin
        if (rst)
            ir <= '0;
        else if (instr_load)
            ir <= instr_out;
    end

    assign opcode = opcode_t'(ir[6:0]);
    assign rd     = ir[11:7];
    assign funct3 = ir[14:12];
    assign rs1    = ir[19:15];
    assign rs2    = ir[24:20];

    assign imm_i = {{20{ir[31]}}, ir[31:20]};                // low 5 bits double as shamt
    assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
    assign imm_b = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
    assign imm_u = {ir[31:12], 12'b0};
    assign imm_j = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

    always_comb
    begin
        case (funct3)
            3'b000:  arith_op = (opcode == opc_op && ir[30]) ? alu_sub : alu_add; // no subi
            3'b001:  arith_op = alu_sll;
            3'b010:  arith_op = alu_slt;
            3'b011:  arith_op = alu_sltu;
            3'b100:  arith_op = alu_xor;
            3'b101:  arith_op = ir[30] ? alu_sra : alu_srl;
            3'b110:  arith_op = alu_or;
            default: arith_op = alu_and;
        endcase
    end

    assign is_load   = (opcode == opc_load);
    assign is_store  = (opcode == opc_store);
    assign is_branch = (opcode == opc_branch);
    assign is_jal    = (opcode == opc_jal);
    assign is_jalr   = (opcode == opc_jalr);
    assign use_pc    = (opcode == opc_auipc);
    assign use_imm   = !(opcode == opc_op || is_branch); // rs2 only for op and compares

    always_comb
    begin
        alu_op = alu_add;
        imm    = imm_i;
        wb_sel = wb_alu;
        rd_we  = 1'b1;
        case (opcode)
            opc_op, opc_op_imm: alu_op = arith_op;
            opc_load:           wb_sel = wb_load;
            opc_store:
            begin
                imm   = imm_s;
                rd_we = 1'b0;
            end
            opc_branch:
            begin
                imm   = imm_b;
                rd_we = 1'b0;
                case (funct3[2:1])
                    2'b10:   alu_op = alu_slt;  // blt, bge
                    2'b11:   alu_op = alu_sltu; // bltu, bgeu
                    default: alu_op = alu_sub;  // beq, bne
                endcase
            end
            opc_jal:
            begin
                imm    = imm_j;
                wb_sel = wb_pc_plus4;
            end
            opc_jalr:           wb_sel = wb_pc_plus4;
            opc_lui:
            begin
                imm    = imm_u;
                alu_op = alu_pass_b;
            end
            opc_auipc:          imm = imm_u;
            default:            rd_we = 1'b0; // unknown opcode only advances the pc
        endcase
        if (rd == '0)
            rd_we = 1'b0; // x0 writes dropped here
    end

endmodule

// ==== reg_file.sv ====
// general register file
`timescale 1ns/1ps
module reg_file (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 we,
    input  rv_isa_pkg::reg_idx_t waddr,
    input  rv_isa_pkg::reg_idx_t raddr1,
    input  rv_isa_pkg::reg_idx_t raddr2,
    input  cpu_types_pkg::word_t wdata,
    output cpu_types_pkg::word_t rdata1,
    output cpu_types_pkg::word_t rdata2
);
    import cpu_types_pkg::*;

    word_t regs [1:31]; // no storage behind x0

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end
        else if (we && waddr != '0)
            regs[waddr] <= wdata;
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    a_x0_zero: assert property (@(posedge clk) disable iff (rst)
        (raddr1 == '0 |-> rdata1 == '0) and (raddr2 == '0 |-> rdata2 == '0));

endmodule

// ==== alu.sv ====
// integer alu and branch compare
`timescale 1ns/1ps
module alu (
    input  rv_isa_pkg::alu_op_t  op,
    input  cpu_types_pkg::word_t a,
    input  cpu_types_pkg::word_t b,
    input  rv_isa_pkg::funct3_t  funct3,
    output cpu_types_pkg::word_t result,
    output logic                 branch_taken
);
    import rv_isa_pkg::*;
    import cpu_types_pkg::*;

    logic [4:0] shamt;
    logic       eq;
    logic       lt;  // signed
    logic       ltu; // unsigned

    assign shamt = b[4:0];
    assign eq    = (a == b);
    assign lt    = ($signed(a) < $signed(b));
    assign ltu   = (a < b);

    always_comb
    begin
        case (op)
            alu_sub:    result = a - b;
            alu_sll:    result = a << shamt;
            alu_slt:    result = {31'b0, lt};
            alu_sltu:   result = {31'b0, ltu};
            alu_xor:    result = a ^ b;
            alu_srl:    result = a >> shamt;
            alu_sra:    result = $signed(a) >>> shamt; // sign bit shifted in
            alu_or:     result = a | b;
            alu_and:    result = a & b;
            alu_pass_b: result = b;
            default:    result = a + b;
        endcase
    end

    // only meaningful while a branch is decoded
    always_comb
    begin
        case (funct3)
            3'b000:  branch_taken = eq;   // beq
            3'b001:  branch_taken = !eq;  // bne
            3'b100:  branch_taken = lt;   // blt
            3'b101:  branch_taken = !lt;  // bge
            3'b110:  branch_taken = ltu;  // bltu
            3'b111:  branch_taken = !ltu; // bgeu
            default: branch_taken = 1'b0;
        endcase
    end

endmodule

// ==== load_store_unit.sv ====
// store lane placement and load extraction
`timescale 1ns/1ps
module load_store_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      mem_write_en,
    input  rv_isa_pkg::funct3_t       funct3,
    input  cpu_types_pkg::word_t      addr,
    input  cpu_types_pkg::word_t      store_data,
    input  cpu_types_pkg::word_t      data_out,
    output cpu_types_pkg::byte_mask_t data_write,
    output cpu_types_pkg::word_t      data_in,
    output cpu_types_pkg::word_t      load_value
);
    import cpu_types_pkg::*;

    logic [1:0] off;    // byte lane within the word
    byte_mask_t mask;
    word_t      rdata_q;
    word_t      byte_sh;
    logic [15:0] half;

    assign off = addr[1:0];

    always_comb
    begin
        mask    = '0;
        data_in = store_data;
        case (funct3)
            3'b000:
            begin
                mask    = 4'b0001 << off;                          // sb on any lane
                data_in = {24'b0, store_data[7:0]} << {off, 3'b0};
            end
            3'b001:
            begin
                if (!off[0])
                    mask = off[1] ? 4'b1100 : 4'b0011;             // sh at 0 or 2 only
                data_in = {16'b0, store_data[15:0]} << {off[1], 4'b0};
            end
            3'b010:
                if (off == 2'b00)
                    mask = 4'b1111;                                // sw aligned only
            default: mask = '0;
        endcase
    end

    assign data_write = mem_write_en ? mask : '0; // single execute-cycle pulse

    // load word valid from mem_wait until the next strobe
    always_ff @(posedge clk)
    begin
        if (rst)
            rdata_q <= '0;
        else
            rdata_q <= data_out;
    end

    assign byte_sh = rdata_q >> {off, 3'b0};
    assign half    = off[1] ? rdata_q[31:16] : rdata_q[15:0];

    always_comb
    begin
        case (funct3)
            3'b000:  load_value = {{24{byte_sh[7]}}, byte_sh[7:0]}; // lb
            3'b001:  load_value = {{16{half[15]}}, half};            // lh
            3'b100:  load_value = {24'b0, byte_sh[7:0]};             // lbu
            3'b101:  load_value = {16'b0, half};                     // lhu
            default: load_value = rdata_q;                           // lw
        endcase
    end

    a_mask_legal: assert property (@(posedge clk) disable iff (rst)
        data_write != '0 |-> data_write inside {4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                                4'b0011, 4'b1100, 4'b1111});

endmodule

// ==== cpu_top.sv ====
// multi-cycle RV32I core
`timescale 1ns/1ps
module cpu_top #(
    parameter cpu_types_pkg::word_t RESET_PC = '0
) (
    input  logic                      clk,
    input  logic                      rst,
    input  cpu_types_pkg::word_t      instr_out,
    input  cpu_types_pkg::word_t      data_out,
    output logic                      instr_read,
    output logic                      data_read,
    output cpu_types_pkg::word_t      instr_addr,
    output cpu_types_pkg::word_t      data_addr,
    output cpu_types_pkg::word_t      data_in,
    output cpu_types_pkg::byte_mask_t data_write
);
    import cpu_types_pkg::*;
    import rv_isa_pkg::*;

    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    funct3_t  funct3;
    alu_op_t  alu_op;
    wb_sel_t  wb_sel;
    word_t    imm;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    alu_a;
    word_t    alu_b;
    word_t    alu_result;
    word_t    load_value;
    word_t    reg_wdata;
    logic     use_imm;
    logic     use_pc;
    logic     rd_we;
    logic     is_load;
    logic     is_store;
    logic     is_branch;
    logic     is_jal;
    logic     is_jalr;
    logic     branch_taken;
    logic     instr_load;
    logic     reg_we_alu;
    logic     reg_we_load;
    logic     mem_write_en;

    assign alu_a     = use_pc ? instr_addr : rs1_data; // auipc takes the pc
    assign alu_b     = use_imm ? imm : rs2_data;
    assign data_addr = alu_result;                     // rs1 + imm for loads and stores

    always_comb
    begin
        case (wb_sel)
            wb_load:     reg_wdata = load_value;
            wb_pc_plus4: reg_wdata = instr_addr + 32'd4; // link address
            default:     reg_wdata = alu_result;
        endcase
    end

    cpu_sequencer #(.RESET_PC(RESET_PC)) u_seq (
        .clk, .rst, .instr_out,
        .is_load, .is_store, .is_branch, .is_jal, .is_jalr, .branch_taken, .rd_we,
        .imm, .alu_result,
        .instr_read, .data_read, .instr_addr,
        .instr_load, .reg_we_alu, .reg_we_load, .mem_write_en
    );

    instr_decoder u_dec (
        .clk, .rst, .instr_load, .instr_out,
        .rs1, .rs2, .rd, .funct3, .imm, .alu_op, .use_imm, .use_pc, .wb_sel,
        .rd_we, .is_load, .is_store, .is_branch, .is_jal, .is_jalr
    );

    reg_file u_rf (
        .clk, .rst,
        .we     (reg_we_alu | reg_we_load),
        .waddr  (rd),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .wdata  (reg_wdata),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    alu u_alu (
        .op (alu_op), .a (alu_a), .b (alu_b), .funct3,
        .result (alu_result), .branch_taken
    );

    load_store_unit u_lsu (
        .clk, .rst, .mem_write_en, .funct3,
        .addr (alu_result), .store_data (rs2_data), .data_out,
        .data_write, .data_in, .load_value
    );

endmodule

// ==== cpu_ref_model.svh ====
// RV32I reference model
`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

word_t ref_regs [0:31];  // architectural registers
word_t ref_mem  [0:63];  // data window of one word per entry

// executes one instruction and returns the next pc and its store
function automatic void ref_exec(input word_t pc, input word_t ins, output word_t npc,
                                 output logic st_valid, output word_t st_addr,
                                 output byte_mask_t st_mask, output word_t st_data);
    word_t a;
    word_t b;
    word_t val;
    word_t immi;
    word_t w;
    word_t bsh;
    logic [15:0] hw;
    logic wr;
    logic take;
    a        = ref_regs[ins[19:15]];
    immi     = {{20{ins[31]}}, ins[31:20]};
    b        = (ins[6:0] == 7'h33) ? ref_regs[ins[24:20]] : immi;
    npc      = pc + 4;
    wr       = 1'b0;
    val      = '0;
    st_valid = 1'b0;
    st_mask  = '0;
    st_data  = '0;
    st_addr  = a + {{20{ins[31]}}, ins[31:25], ins[11:7]}; // store address
    case (ins[6:0])
        7'h33, 7'h13:
        begin
            wr = 1'b1;
            case (ins[14:12])
                3'd0: val = (ins[6:0] == 7'h33 && ins[30]) ? a - b : a + b;
                3'd1: val = a << b[4:0];
                3'd2: val = {31'b0, $signed(a) < $signed(b)};
                3'd3: val = {31'b0, a < b};
                3'd4: val = a ^ b;
                3'd5: val = ins[30] ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
                3'd6: val = a | b;
                default: val = a & b;
            endcase
        end
        7'h37:
        begin
            wr  = 1'b1;
            val = {ins[31:12], 12'b0};
        end
        7'h17:
        begin
            wr  = 1'b1;
            val = pc + {ins[31:12], 12'b0};
        end
        7'h6f:
        begin
            wr  = 1'b1;
            val = pc + 4;
            npc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        end
        7'h67:
        begin
            wr  = 1'b1;
            val = pc + 4;
            npc = (a + immi) & ~32'd1;
        end
        7'h63:
        begin
            b = ref_regs[ins[24:20]];
            case (ins[14:12])
                3'd0: take = (a == b);
                3'd1: take = (a != b);
                3'd4: take = $signed(a) < $signed(b);
                3'd5: take = $signed(a) >= $signed(b);
                3'd6: take = a < b;
                default: take = a >= b;
            endcase
            if (take)
                npc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        end
        7'h03:
        begin
            wr  = 1'b1;
            a   = a + immi;
            w   = ref_mem[a[7:2]];
            bsh = w >> {a[1:0], 3'b0};
            hw  = a[1] ? w[31:16] : w[15:0];
            case (ins[14:12])
                3'd0: val = {{24{bsh[7]}}, bsh[7:0]};
                3'd1: val = {{16{hw[15]}}, hw};
                3'd4: val = {24'b0, bsh[7:0]};
                3'd5: val = {16'b0, hw};
                default: val = w;
            endcase
        end
        7'h23:
        begin
            b = ref_regs[ins[24:20]];
            case (ins[14:12])
                3'd0:
                begin
                    st_mask = 4'b0001 << st_addr[1:0];
                    st_data = {4{b[7:0]}};
                end
                3'd1:
                begin
                    if (!st_addr[0])
                        st_mask = st_addr[1] ? 4'b1100 : 4'b0011; // halfword lanes only
                    st_data = {2{b[15:0]}};
                end
                3'd2:
                begin
                    if (st_addr[1:0] == 2'b00)
                        st_mask = 4'b1111;
                    st_data = b;
                end
                default: st_mask = '0;
            endcase
            for (int i = 0; i < 4; i++)
                if (st_mask[i])
                    ref_mem[st_addr[7:2]][i*8 +: 8] = st_data[i*8 +: 8];
            st_valid = (st_mask != '0);
        end
        default: wr = 1'b0; // unknown opcode
    endcase
    if (wr && ins[11:7] != 5'd0)
        ref_regs[ins[11:7]] = val;
endfunction

task automatic check_word(input string name, input word_t exp, input word_t act);
    if (exp !== act)
    begin
        mismatches++;
        $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
    end
endtask

task automatic check_mask(input string name, input byte_mask_t exp, input byte_mask_t act);
    if (exp !== act)
    begin
        mismatches++;
        $display("Mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
    end
endtask

`endif

// ==== tb_cpu_top.sv ====
// cpu_top testbench
`timescale 1ns/1ps
module tb_cpu_top;
    import cpu_types_pkg::*;

    localparam word_t RESET_PC = 32'h0000_0100;
    localparam int    N        = 160;                   // program length
    localparam word_t HALT_PC  = RESET_PC + 4 * (N - 1); // self loop at the end

    logic       clk;
    logic       rst;
    word_t      instr_out;
    word_t      data_out;
    logic       instr_read;
    logic       data_read;
    word_t      instr_addr;
    word_t      data_addr;
    word_t      data_in;
    byte_mask_t data_write;

    int    mismatches = 0;
    int    failures   = 0;  // protocol and hang errors
    word_t lfsr       = 32'hbae3_6cd5;
    word_t imem [0:255];
    word_t dmem [0:63];
    word_t ifetch_q;
    word_t dread_q;
    word_t exp_pc;
    word_t st_addr;
    word_t st_data;
    byte_mask_t st_mask;
    logic  st_pending = 1'b0;
    logic  seen_fetch = 1'b0;
    logic  done       = 1'b0;
    int    cyc        = 0;

    `include "cpu_ref_model.svh"

    cpu_top #(.RESET_PC(RESET_PC)) DUT (.*);

    function automatic logic next_bit();
        logic b;
        b    = lfsr[0];
        lfsr = lfsr >> 1;
        if (b)
            lfsr ^= 32'h8020_0003; // galois taps
        return b;
    endfunction

    function automatic word_t take_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[30:0], next_bit()};
        return v;
    endfunction

    function automatic word_t fill_word(input int i);
        word_t a;
        a = 32'h1000 + 4 * i;
        return (a * 32'h9e37_79b9) ^ {a[15:0], ~a[15:0]};
    endfunction

    function automatic logic [4:0] pick_rd();
        logic [4:0] r;
        r = take_bits(4);
        return (r == 5'd1) ? 5'd0 : r; // x1 keeps the data base
    endfunction

    function automatic word_t lane_bits(input byte_mask_t m);
        return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
    endfunction

    task automatic build_program();
        word_t ins;
        word_t imm;
        int    kind;
        int    tgt;
        logic [2:0] f3;
        logic [12:0] boff;
        logic [20:0] joff;
        imem[0] = {20'h1, 5'd1, 7'h37}; // lui x1, 0x1000 base
        for (int i = 1; i < N - 1; i++)
        begin
            kind = take_bits(4);
            f3   = take_bits(3);
            tgt  = i + 2 + take_bits(2);          // forward only
            if (tgt > N - 1)
                tgt = N - 1;
            boff = 13'(4 * (tgt - i));
            joff = 21'(4 * (tgt - i));
            if (kind <= 2)
                ins = {1'b0, next_bit() && (f3 == 0 || f3 == 5), 5'b0, 5'(take_bits(4)),
                       5'(take_bits(4)), f3, pick_rd(), 7'h33};
            else if (kind <= 5)
            begin
                imm = take_bits(12);
                if (f3 == 1)
                    imm[11:5] = '0;
                if (f3 == 5)
                    imm[11:5] = {1'b0, next_bit(), 5'b0}; // srai or srli
                ins = {imm[11:0], 5'(take_bits(4)), f3, pick_rd(), 7'h13};
            end
            else if (kind <= 7)
                ins = {20'(take_bits(20)), pick_rd(), (kind == 6) ? 7'h37 : 7'h17};
            else if (kind <= 9)
            begin
                f3  = (f3 % 5 == 3) ? 3'd4 : (f3 % 5 == 4) ? 3'd5 : 3'(f3 % 5);
                imm = take_bits(8);
                if (f3 == 2)
                    imm[1:0] = 2'b00;
                else if (f3 != 0 && f3 != 4)
                    imm[0] = 1'b0;  // aligned halfword loads
                ins = {imm[11:0], 5'd1, f3, pick_rd(), 7'h03};
            end
            else if (kind <= 12)
            begin
                f3  = f3 % 3;
                imm = take_bits(8);
                if (f3 == 2 && next_bit())
                    imm[1:0] = 2'b00; // mostly aligned sw
                ins = {imm[11:5], 5'(take_bits(4)), 5'd1, f3, imm[4:0], 7'h23};
            end
            else if (kind == 13)
            begin
                if (f3 == 2 || f3 == 3)
                    f3 = f3 + 2;
                ins = {boff[12], boff[10:5], 5'(take_bits(4)), 5'(take_bits(4)), f3,
                       boff[4:1], boff[11], 7'h63};
            end
            else if (kind == 14)
                ins = {joff[20], joff[10:1], joff[11], joff[19:12], pick_rd(), 7'h6f};
            else if (next_bit())
                ins = {12'(RESET_PC + 4 * tgt), 5'd0, 3'd0, pick_rd(), 7'h67}; // absolute jalr
            else
                ins = {25'(take_bits(25)), 7'h0b}; // unknown opcode
            imem[i] = ins;
        end
        imem[N - 1] = {20'b0, 5'd0, 7'h6f}; // jal x0, 0
    endtask

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // memory models sample strobes on the rising edge
    always @(posedge clk)
    begin
        if (instr_read)
            ifetch_q <= imem[(instr_addr - RESET_PC) >> 2];
        if (data_read)
            dread_q <= dmem[data_addr[7:2]];
        for (int i = 0; i < 4; i++)
            if (data_write[i])
                dmem[data_addr[7:2]][i*8 +: 8] <= data_in[i*8 +: 8];
    end

    always @(negedge clk)
    begin
        instr_out <= ifetch_q; // presented one cycle after the strobe
        data_out  <= dread_q;
    end

    // compare fetches and writes with the reference model
    always @(posedge clk)
    begin
        if (!rst && !done)
        begin
            cyc++;
            if (instr_read)
            begin
                if (seen_fetch && cyc != CYCLES_PER_INSTR)
                begin
                    failures++;
                    $display("Fetch strobes %0d cycles apart at %0t", cyc, $time);
                end
                if (st_pending)
                begin
                    failures++;
                    $display("Expected store did not happen before %0t", $time);
                end
                cyc        = 0;
                seen_fetch = 1'b1;
                check_word("instr_addr", exp_pc, instr_addr);
                if (exp_pc == HALT_PC)
                    done = 1'b1;
                else
                    ref_exec(exp_pc, imem[(exp_pc - RESET_PC) >> 2], exp_pc, st_pending,
                             st_addr, st_mask, st_data);
            end
            if (data_write != '0)
            begin
                if (!st_pending)
                begin
                    failures++;
                    $display("Unexpected write pulse at %0t", $time);
                end
                else
                begin
                    check_word("data_addr", st_addr, data_addr);
                    check_mask("data_write", st_mask, data_write);
                    check_word("data_in", st_data & lane_bits(st_mask),
                               data_in & lane_bits(st_mask));
                end
                st_pending = 1'b0;
            end
        end
    end

    initial
    begin
        rst       = 1'b1;
        instr_out = '0;
        data_out  = '0;
        ifetch_q  = '0;
        dread_q   = '0;
        exp_pc    = RESET_PC;
        for (int i = 0; i < 64; i++)
        begin
            dmem[i]     = fill_word(i);
            ref_mem[i]  = fill_word(i);
        end
        for (int i = 0; i < 32; i++)
            ref_regs[i] = '0;
        build_program();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_word("instr_addr", RESET_PC, instr_addr); // state right after reset
        if (instr_read !== 1'b1 || data_read !== 1'b0 || data_write !== '0)
        begin
            failures++;
            $display("Strobes wrong after reset at %0t", $time);
        end
        wait (done);
        $display("mismatches %0d, other errors %0d", mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    // watchdog sized to the program plus reset and margin
    initial
    begin
        #((N * CYCLES_PER_INSTR + 10 + 40) * 40);
        $display("Run hung before the program reached its end");
        $display("Regression failed");
        $finish;
    end

endmodule

// ==== cpu_top.f ====
rv_isa_pkg.sv
cpu_types_pkg.sv
cpu_sequencer.sv
instr_decoder.sv
reg_file.sv
alu.sv
load_store_unit.sv
cpu_top.sv
+incdir+.
tb_cpu_top.sv

// ==== Bender.yml ====
package:
  name: cpu_top

sources:
  - files:
      - rv_isa_pkg.sv
      - cpu_types_pkg.sv
      - cpu_sequencer.sv
      - instr_decoder.sv
      - reg_file.sv
      - alu.sv
      - load_store_unit.sv
      - cpu_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_cpu_top.sv
